/* source/issue_pkg.sv */
package issue_pkg;

	// datapath and register file
	localparam int XLEN = 32;
	localparam int NREG = 32;
	localparam int REG_AW = $clog2(NREG);
	localparam int TAG_W = 8;
	localparam int IMM_W = 16;

	// instruction queue, power of two so pointers wrap on their own
	localparam int QUEUE_DEPTH = 8;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	// multiply occupies ex this many cycles
	localparam int MUL_CYCLES = 3;
	localparam int MUL_CNT_W = $clog2(MUL_CYCLES + 1);

	typedef logic [QPTR_W-1:0] qptr_t;
	typedef logic [QPTR_W:0] qcnt_t;
	typedef logic [MUL_CNT_W-1:0] mul_cnt_t;

	typedef enum logic [1:0] {
		OP_ADD  = 2'd0,
		OP_ADDI = 2'd1,
		OP_SUB  = 2'd2,
		OP_MUL  = 2'd3
	} op_t;

	// decoded instruction as it leaves the frontend
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		op_t op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs0;
		// ignored for addi, which reads r0 instead
		logic [REG_AW-1:0] rs1;
		logic [IMM_W-1:0] imm;
	} inst_t;

	// per-operand bypass select for the ex stage
	typedef struct packed {
		// producing pipe
		logic pipe_sel;
		// bit 0 regfile, bits 1..3 producer m1 / m2 / wb
		logic [3:0] ex_src;
	} forwarding_info_t;

	// multiply has to go down pipe 1
	function automatic logic is_pipe_two_only(input op_t op);
		return op == OP_MUL;
	endfunction

	// result usable for bypass right out of ex
	function automatic logic ready_at_ex(input op_t op);
		return op != OP_MUL;
	endfunction

endpackage

/* source/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_valid_i,
	output logic inst_ready_o,
	input  issue_pkg::inst_t inst_i,
	output issue_pkg::inst_t [1:0] head_inst_o,
	output logic [1:0] head_valid_o,
	input  logic [1:0] pop_i,
	input  logic stall_i
);

	issue_pkg::inst_t mem [issue_pkg::QUEUE_DEPTH];
	issue_pkg::qptr_t wr_ptr;
	issue_pkg::qptr_t rd_ptr;
	issue_pkg::qptr_t rd_ptr_next;
	issue_pkg::qcnt_t count;
	logic push;
	logic [1:0] pop_cnt;

	// accept only while there is room
	assign inst_ready_o = count != issue_pkg::qcnt_t'(issue_pkg::QUEUE_DEPTH);
	assign push = inst_valid_i & inst_ready_o;

	// issue hands back 00, 01 or 11, nothing leaves while the backend is frozen
	assign pop_cnt = stall_i ? 2'd0 : {1'b0, pop_i[0]} + {1'b0, pop_i[1]};

	// two oldest entries
	assign rd_ptr_next = rd_ptr + 1'b1;
	assign head_inst_o[0] = mem[rd_ptr];
	assign head_inst_o[1] = mem[rd_ptr_next];
	assign head_valid_o[0] = count != '0;
	assign head_valid_o[1] = count > issue_pkg::qcnt_t'(1);

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= inst_i;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_ptr + issue_pkg::qptr_t'(pop_cnt);
			// one in, up to two out on the same edge
			count <= count + issue_pkg::qcnt_t'(push) - issue_pkg::qcnt_t'(pop_cnt);
		end
	end

endmodule

/* source/issue.sv */
`timescale 1ns/1ps

module issue (
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::inst_t [1:0] inst_i,
	input  logic [1:0] inst_valid_i,
	input  logic stall_i,
	output logic [1:0] issue_o,
	output logic revert_o,
	output issue_pkg::forwarding_info_t [1:0][1:0] forwarding_info_o
);

	// one entry per architectural register
	typedef struct packed {
		// pipe holding the newest writer
		logic pipe_sel;
		// one-hot ex / m1 / m2, moves up
		logic [2:0] pos;
		// bypass readiness, moves down toward bit 0
		logic [2:0] ready;
	} sb_entry_t;

	sb_entry_t [issue_pkg::NREG-1:0] sb_q;
	sb_entry_t [issue_pkg::NREG-1:0] sb_d;
	logic [1:0][1:0][issue_pkg::REG_AW-1:0] src;
	logic [1:0] raw;
	logic pair_data_conflict;
	logic pair_mul_conflict;
	logic issue_first;
	logic issue_second;

	// writer in flight and not yet forwardable to an ex consumer
	function automatic logic blocked(input sb_entry_t e);
		return (e.pos != 3'b000) && !e.ready[0];
	endfunction

	// bypass select as seen one cycle later, once the consumer sits in ex
	function automatic issue_pkg::forwarding_info_t fwd_of(input sb_entry_t e);
		issue_pkg::forwarding_info_t f;
		f.pipe_sel = e.pipe_sel;
		// ex -> m1, m1 -> m2, m2 -> wb by the time it is used
		f.ex_src[3:1] = e.pos & {3{e.ready[0]}};
		// nothing in flight, take the regfile value
		f.ex_src[0] = ~|f.ex_src[3:1];
		return f;
	endfunction

	// effective sources, addi reads r0 in place of rs1
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			src[i][0] = inst_i[i].rs0;
			src[i][1] = (inst_i[i].op == issue_pkg::OP_ADDI) ? '0 : inst_i[i].rs1;
		end
	end

	// raw hazard per head against the scoreboard
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			raw[i] = blocked(sb_q[src[i][0]]) | blocked(sb_q[src[i][1]]);
		end
	end

	// the pair must be independent, and only one of them may be a multiply
	assign pair_data_conflict = (inst_i[0].rd != '0) &&
		((inst_i[0].rd == src[1][0]) || (inst_i[0].rd == src[1][1]) ||
		(inst_i[0].rd == inst_i[1].rd));
	assign pair_mul_conflict = issue_pkg::is_pipe_two_only(inst_i[0].op) &&
		issue_pkg::is_pipe_two_only(inst_i[1].op);

	// strictly in order, head 1 never goes alone
	assign issue_first = inst_valid_i[0] & ~stall_i & ~raw[0];
	assign issue_second = issue_first & inst_valid_i[1] & ~raw[1] &
		~pair_data_conflict & ~pair_mul_conflict;
	assign issue_o = {issue_second, issue_first};

	// head 0 multiply goes to pipe 1, head 1 then lands in pipe 0
	assign revert_o = issue_first & issue_pkg::is_pipe_two_only(inst_i[0].op);

	for (genvar i = 0; i < 2; i++) begin : g_head
		for (genvar j = 0; j < 2; j++) begin : g_src
			assign forwarding_info_o[i][j] = fwd_of(sb_q[src[i][j]]);
		end
	end

	// advance all entries unless frozen, then load issuing writers
	always_comb begin
		for (int r = 0; r < issue_pkg::NREG; r++) begin
			sb_d[r] = sb_q[r];
			if (!stall_i) begin
				sb_d[r].pos = {sb_q[r].pos[1:0], 1'b0};
				sb_d[r].ready = {1'b0, sb_q[r].ready[2:1]};
			end
			for (int i = 0; i < 2; i++) begin
				// r0 is never tracked
				if (issue_o[i] && (r != 0) && (int'(inst_i[i].rd) == r)) begin
					sb_d[r].pipe_sel = i[0] ^ revert_o;
					sb_d[r].pos = 3'b001;
					// multiply only forwardable from m2 on
					sb_d[r].ready = issue_pkg::ready_at_ex(inst_i[i].op) ? 3'b111 : 3'b100;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			sb_q <= sb_d;
		end
	end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic clk,
	input  logic rst_n,
	input  logic [3:0][issue_pkg::REG_AW-1:0] raddr_i,
	output logic [3:0][issue_pkg::XLEN-1:0] rdata_o,
	input  logic [1:0] we_i,
	input  logic [1:0][issue_pkg::REG_AW-1:0] waddr_i,
	input  logic [1:0][issue_pkg::XLEN-1:0] wdata_i
);

	logic [issue_pkg::XLEN-1:0] regs [issue_pkg::NREG];

	// async read, two ports per issue slot
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			rdata_o[p] = regs[raddr_i[p]];
		end
	end

	// both pipes write at the end of m2
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < issue_pkg::NREG; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int w = 0; w < 2; w++) begin
				// r0 stays zero
				if (we_i[w] && (waddr_i[w] != '0)) begin
					regs[waddr_i[w]] <= wdata_i[w];
				end
			end
		end
	end

endmodule

/* source/mul_timer.sv */
`timescale 1ns/1ps

module mul_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic ex_mul_i,
	output logic stall_o
);

	issue_pkg::mul_cnt_t cnt;

	// multiply just entered ex, keep it there for the remaining cycles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (ex_mul_i) begin
			cnt <= issue_pkg::mul_cnt_t'(issue_pkg::MUL_CYCLES - 1);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// backend and issue frozen while counting down
	assign stall_o = cnt != '0;

endmodule

/* source/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe #(
	parameter int PIPE_ID = 0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic stall_i,
	input  logic valid_i,
	input  issue_pkg::inst_t inst_i,
	input  issue_pkg::forwarding_info_t [1:0] fwd_i,
	input  logic [1:0][issue_pkg::XLEN-1:0] rdata_i,
	output logic [2:0][issue_pkg::XLEN-1:0] own_fwd_o,
	input  logic [2:0][issue_pkg::XLEN-1:0] other_fwd_i,
	output logic ex_mul_o,
	output logic wb_we_o,
	output logic [issue_pkg::REG_AW-1:0] wb_rd_o,
	output logic [issue_pkg::XLEN-1:0] wb_data_o,
	output logic retire_valid_o,
	output logic [issue_pkg::TAG_W-1:0] retire_tag_o,
	output logic [issue_pkg::REG_AW-1:0] retire_rd_o,
	output logic [issue_pkg::XLEN-1:0] retire_value_o
);

	logic ex_valid;
	issue_pkg::inst_t ex_inst;
	logic [1:0][issue_pkg::XLEN-1:0] ex_rdata;
	issue_pkg::forwarding_info_t [1:0] ex_fwd;
	logic [1:0][issue_pkg::XLEN-1:0] opnd;
	logic [issue_pkg::XLEN-1:0] imm_ext;
	logic [issue_pkg::XLEN-1:0] op_b;
	logic [issue_pkg::XLEN-1:0] product;
	logic [issue_pkg::XLEN-1:0] alu_res;
	logic m1_valid;
	logic [issue_pkg::TAG_W-1:0] m1_tag;
	logic [issue_pkg::REG_AW-1:0] m1_rd;
	logic [issue_pkg::XLEN-1:0] m1_res;
	logic m2_valid;
	logic [issue_pkg::TAG_W-1:0] m2_tag;
	logic [issue_pkg::REG_AW-1:0] m2_rd;
	logic [issue_pkg::XLEN-1:0] m2_res;
	logic [issue_pkg::XLEN-1:0] wb_res;

	// long-latency op entering ex on this edge, starts the backend hold
	assign ex_mul_o = valid_i & ~stall_i & ~issue_pkg::ready_at_ex(inst_i.op);

	// results offered to both pipes' ex bypass
	assign own_fwd_o = {wb_res, m2_res, m1_res};

	// stage valids
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			m1_valid <= 1'b0;
			m2_valid <= 1'b0;
		end else if (!stall_i) begin
			ex_valid <= valid_i;
			m1_valid <= ex_valid;
			m2_valid <= m1_valid;
		end
	end

	// payload, frozen together with the valids
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ex_inst <= inst_i;
			ex_rdata <= rdata_i;
			ex_fwd <= fwd_i;
			m1_tag <= ex_inst.tag;
			m1_rd <= ex_inst.rd;
			m1_res <= alu_res;
			m2_tag <= m1_tag;
			m2_rd <= m1_rd;
			m2_res <= m1_res;
			// only kept for bypass, the regfile is written from m2
			wb_res <= m2_res;
		end
	end

	// operand bypass, one-hot and-or mux
	always_comb begin
		logic [2:0][issue_pkg::XLEN-1:0] src_set;
		for (int j = 0; j < 2; j++) begin
			src_set = (ex_fwd[j].pipe_sel == (PIPE_ID != 0)) ? own_fwd_o : other_fwd_i;
			opnd[j] = ({issue_pkg::XLEN{ex_fwd[j].ex_src[0]}} & ex_rdata[j]) |
				({issue_pkg::XLEN{ex_fwd[j].ex_src[1]}} & src_set[0]) |
				({issue_pkg::XLEN{ex_fwd[j].ex_src[2]}} & src_set[1]) |
				({issue_pkg::XLEN{ex_fwd[j].ex_src[3]}} & src_set[2]);
		end
	end

	// alu
	assign imm_ext = {{(issue_pkg::XLEN - issue_pkg::IMM_W){ex_inst.imm[issue_pkg::IMM_W-1]}},
		ex_inst.imm};
	assign op_b = (ex_inst.op == issue_pkg::OP_ADDI) ? imm_ext : opnd[1];

	// multiplier only exists in pipe 1, low word kept
	assign product = (PIPE_ID == 1) ? opnd[0] * opnd[1] : '0;

	always_comb begin
		if (issue_pkg::is_pipe_two_only(ex_inst.op)) begin
			alu_res = product;
		end else if (ex_inst.op == issue_pkg::OP_SUB) begin
			alu_res = opnd[0] - op_b;
		end else begin
			// add and addi
			alu_res = opnd[0] + op_b;
		end
	end

	// m2 retires once, on the cycle it actually leaves
	assign retire_valid_o = m2_valid & ~stall_i;
	assign retire_tag_o = m2_tag;
	assign retire_rd_o = m2_rd;
	assign retire_value_o = m2_res;

	// register write on the same edge
	assign wb_we_o = m2_valid & ~stall_i;
	assign wb_rd_o = m2_rd;
	assign wb_data_o = m2_res;

endmodule

/* source/dual_issue_top.sv */
`timescale 1ns/1ps

module dual_issue_top (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_valid_i,
	output logic inst_ready_o,
	input  issue_pkg::inst_t inst_i,
	output logic [1:0] retire_valid_o,
	output logic [1:0][issue_pkg::TAG_W-1:0] retire_tag_o,
	output logic [1:0][issue_pkg::REG_AW-1:0] retire_rd_o,
	output logic [1:0][issue_pkg::XLEN-1:0] retire_value_o
);

	issue_pkg::inst_t [1:0] head_inst;
	logic [1:0] head_valid;
	logic [1:0] issue_vec;
	logic revert;
	logic stall;
	logic ex_mul;
	issue_pkg::forwarding_info_t [1:0][1:0] head_fwd;
	logic [3:0][issue_pkg::REG_AW-1:0] raddr;
	logic [3:0][issue_pkg::XLEN-1:0] rdata;
	issue_pkg::inst_t [1:0] pipe_inst;
	logic [1:0] pipe_valid;
	issue_pkg::forwarding_info_t [1:0][1:0] pipe_fwd;
	logic [1:0][1:0][issue_pkg::XLEN-1:0] pipe_rdata;
	logic [1:0][2:0][issue_pkg::XLEN-1:0] fwd_set;
	logic [1:0] wb_we;
	logic [1:0][issue_pkg::REG_AW-1:0] wb_rd;
	logic [1:0][issue_pkg::XLEN-1:0] wb_data;

	// regfile ports 0,1 for head 0, ports 2,3 for head 1
	assign raddr = {head_inst[1].rs1, head_inst[1].rs0, head_inst[0].rs1, head_inst[0].rs0};

	// lane mapping, pipe p takes head p, or the other head when swapped
	always_comb begin
		logic lane;
		for (int p = 0; p < 2; p++) begin
			lane = p[0] ^ revert;
			pipe_inst[p] = head_inst[lane];
			pipe_valid[p] = issue_vec[lane];
			pipe_fwd[p] = head_fwd[lane];
			pipe_rdata[p] = lane ? rdata[3:2] : rdata[1:0];
		end
	end

	inst_queue u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst_valid_i (inst_valid_i),
		.inst_ready_o (inst_ready_o),
		.inst_i       (inst_i),
		.head_inst_o  (head_inst),
		.head_valid_o (head_valid),
		.pop_i        (issue_vec),
		.stall_i      (stall)
	);

	issue u_issue (
		.clk               (clk),
		.rst_n             (rst_n),
		.inst_i            (head_inst),
		.inst_valid_i      (head_valid),
		.stall_i           (stall),
		.issue_o           (issue_vec),
		.revert_o          (revert),
		.forwarding_info_o (head_fwd)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_i (raddr),
		.rdata_o (rdata),
		.we_i    (wb_we),
		.waddr_i (wb_rd),
		.wdata_i (wb_data)
	);

	// only pipe 1 ever sees a multiply
	mul_timer u_mul_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mul_i (ex_mul),
		.stall_o  (stall)
	);

	exec_pipe #(
		.PIPE_ID (0)
	) u_pipe0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.stall_i        (stall),
		.valid_i        (pipe_valid[0]),
		.inst_i         (pipe_inst[0]),
		.fwd_i          (pipe_fwd[0]),
		.rdata_i        (pipe_rdata[0]),
		.own_fwd_o      (fwd_set[0]),
		.other_fwd_i    (fwd_set[1]),
		.ex_mul_o       (),
		.wb_we_o        (wb_we[0]),
		.wb_rd_o        (wb_rd[0]),
		.wb_data_o      (wb_data[0]),
		.retire_valid_o (retire_valid_o[0]),
		.retire_tag_o   (retire_tag_o[0]),
		.retire_rd_o    (retire_rd_o[0]),
		.retire_value_o (retire_value_o[0])
	);

	exec_pipe #(
		.PIPE_ID (1)
	) u_pipe1 (
		.clk            (clk),
		.rst_n          (rst_n),
		.stall_i        (stall),
		.valid_i        (pipe_valid[1]),
		.inst_i         (pipe_inst[1]),
		.fwd_i          (pipe_fwd[1]),
		.rdata_i        (pipe_rdata[1]),
		.own_fwd_o      (fwd_set[1]),
		.other_fwd_i    (fwd_set[0]),
		.ex_mul_o       (ex_mul),
		.wb_we_o        (wb_we[1]),
		.wb_rd_o        (wb_rd[1]),
		.wb_data_o      (wb_data[1]),
		.retire_valid_o (retire_valid_o[1]),
		.retire_tag_o   (retire_tag_o[1]),
		.retire_rd_o    (retire_rd_o[1]),
		.retire_value_o (retire_value_o[1])
	);

endmodule

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 16-bit immediate, sign extended to a data word
function automatic logic [31:0] sext_imm(input logic [15:0] imm);
	return {{16{imm[15]}}, imm};
endfunction

// architectural read, r0 always reads zero
function automatic logic [31:0] read_ref(input int r);
	return (r == 0) ? 32'h0 : ref_regs[r];
endfunction

// value of one instruction from its two source values
function automatic logic [31:0] ref_result(input issue_pkg::inst_t ins,
		input logic [31:0] a, input logic [31:0] b);
	logic [63:0] full;
	full = 64'(a) * 64'(b);
	case (ins.op)
		issue_pkg::OP_ADD: return a + b;
		issue_pkg::OP_ADDI: return a + sext_imm(ins.imm);
		issue_pkg::OP_SUB: return a - b;
		// multiply keeps the low word
		default: return full[31:0];
	endcase
endfunction

// whole program in order, fills expected rd and value per tag
function automatic void run_reference();
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	for (int r = 0; r < issue_pkg::NREG; r++) begin
		ref_regs[r] = '0;
	end
	for (int i = 0; i < PROG_LEN; i++) begin
		a = read_ref(int'(prog[i].rs0));
		// addi has no second register source
		b = (prog[i].op == issue_pkg::OP_ADDI) ? 32'h0 : read_ref(int'(prog[i].rs1));
		res = ref_result(prog[i], a, b);
		exp_rd[i] = prog[i].rd;
		exp_value[i] = res;
		// writer of r0 still retires its value, r0 itself stays zero
		if (prog[i].rd != '0) begin
			ref_regs[prog[i].rd] = res;
		end
	end
endfunction

`endif

/* test/tb_dual_issue.sv */
`timescale 1ns/1ps

module tb_dual_issue;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 5;
	localparam int RESET_CYCLES = 5;
	localparam int PROG_LEN = 200;
	// program sections: random alu, multiplies, back-pressure, independent, r0
	localparam int B_START = 75;
	localparam int D_START = 115;
	localparam int C_START = 135;
	localparam int E_START = 165;
	localparam logic [31:0] LFSR_SEED = 32'he32b_f392;
	localparam int WATCHDOG_NS = PROG_LEN * (issue_pkg::MUL_CYCLES + 4) * CLK_PERIOD +
		(RESET_CYCLES + 2) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic inst_valid;
	logic inst_ready;
	issue_pkg::inst_t inst;
	logic [1:0] retire_valid;
	logic [1:0][issue_pkg::TAG_W-1:0] retire_tag;
	logic [1:0][issue_pkg::REG_AW-1:0] retire_rd;
	logic [1:0][issue_pkg::XLEN-1:0] retire_value;

	// program and expected results per tag
	issue_pkg::inst_t prog [PROG_LEN];
	logic [issue_pkg::REG_AW-1:0] exp_rd [PROG_LEN];
	logic [31:0] exp_value [PROG_LEN];
	logic [31:0] ref_regs [issue_pkg::NREG];
	int retire_cycle [PROG_LEN];

	logic [31:0] lfsr_state;
	int next_tag;
	int cycle_cnt;
	int dual_in_block;
	int stalled_pushes;

	`include "tb_ref_model.svh"

	dual_issue_top uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.inst_valid_i   (inst_valid),
		.inst_ready_o   (inst_ready),
		.inst_i         (inst),
		.retire_valid_o (retire_valid),
		.retire_tag_o   (retire_tag),
		.retire_rd_o    (retire_rd),
		.retire_value_o (retire_value)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	function automatic string mismatch_text(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		return $sformatf("CHECK FAILED %s got 0x%h expected 0x%h", sig, got, exp);
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit taken, newest bit lands in the lsb
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// small pool r1..r5 so hazards are frequent
	function automatic int pick_reg();
		logic [2:0] sel;
		sel = 3'(take_bits(3));
		return (int'(sel) % 5) + 1;
	endfunction

	function automatic issue_pkg::op_t rand_alu_op();
		logic [1:0] sel;
		sel = 2'(take_bits(2));
		case (sel)
			2'd1: return issue_pkg::OP_ADDI;
			2'd2: return issue_pkg::OP_SUB;
			default: return issue_pkg::OP_ADD;
		endcase
	endfunction

	function automatic issue_pkg::inst_t make_inst(input issue_pkg::op_t op, input int rd,
			input int rs0, input int rs1, input logic [15:0] imm);
		issue_pkg::inst_t ins;
		ins.tag = '0;
		ins.op = op;
		ins.rd = issue_pkg::REG_AW'(rd);
		ins.rs0 = issue_pkg::REG_AW'(rs0);
		ins.rs1 = issue_pkg::REG_AW'(rs1);
		ins.imm = imm;
		return ins;
	endfunction

	function automatic void build_program();
		int n;
		int prev_rd;
		int rd;
		int s0;
		int s1;
		issue_pkg::op_t op;
		logic [15:0] imm;
		n = 0;
		// nonzero seeds in the pool
		for (int r = 1; r <= 5; r++) begin
			imm = 16'(take_bits(16));
			prog[n] = make_inst(issue_pkg::OP_ADDI, r, 0, 0, imm);
			n++;
		end
		prev_rd = 5;
		// random alu ops, about half read the previous result
		while (n < B_START) begin
			op = rand_alu_op();
			rd = pick_reg();
			s0 = take_bits(1) ? prev_rd : pick_reg();
			s1 = pick_reg();
			imm = 16'(take_bits(16));
			prog[n] = make_inst(op, rd, s0, s1, imm);
			prev_rd = rd;
			n++;
		end
		// mul, its direct consumer, then a mul pair
		while (n < D_START) begin
			rd = pick_reg();
			s0 = pick_reg();
			s1 = pick_reg();
			prog[n] = make_inst(issue_pkg::OP_MUL, rd, s0, s1, 16'h0);
			s1 = pick_reg();
			prog[n + 1] = make_inst(issue_pkg::OP_ADD, pick_reg(), rd, s1, 16'h0);
			s0 = pick_reg();
			s1 = pick_reg();
			prog[n + 2] = make_inst(issue_pkg::OP_MUL, pick_reg(), s0, s1, 16'h0);
			s0 = pick_reg();
			s1 = pick_reg();
			prog[n + 3] = make_inst(issue_pkg::OP_MUL, pick_reg(), s0, s1, 16'h0);
			n += 4;
		end
		// dependent multiply chain on r12 fills the queue
		imm = 16'(take_bits(16)) | 16'h1;
		prog[n] = make_inst(issue_pkg::OP_ADDI, 12, 0, 0, imm);
		n++;
		while (n < C_START) begin
			prog[n] = make_inst(issue_pkg::OP_MUL, 12, 12, pick_reg(), 16'h0);
			n++;
		end
		// independent block, r6..r11 written and never read here
		while (n < E_START) begin
			op = rand_alu_op();
			s0 = pick_reg();
			s1 = pick_reg();
			imm = 16'(take_bits(16));
			prog[n] = make_inst(op, 6 + ((n - C_START) % 6), s0, s1, imm);
			n++;
		end
		// writes to r0 and reads of r0
		while (n < PROG_LEN) begin
			imm = 16'(take_bits(16));
			prog[n] = make_inst(issue_pkg::OP_ADDI, 0, pick_reg(), 0, imm);
			prog[n + 1] = make_inst(issue_pkg::OP_ADD, 13, 0, pick_reg(), 16'h0);
			prog[n + 2] = make_inst(issue_pkg::OP_SUB, 14, pick_reg(), 0, 16'h0);
			s0 = pick_reg();
			s1 = pick_reg();
			prog[n + 3] = make_inst(issue_pkg::OP_MUL, 0, s0, s1, 16'h0);
			prog[n + 4] = make_inst(issue_pkg::OP_ADD, 15, 0, 0, 16'h0);
			n += 5;
		end
		// sequential tags
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i].tag = issue_pkg::TAG_W'(i);
		end
	endfunction

	// holds valid and data until ready is seen before the edge
	task automatic push_program();
		int i;
		logic taken;
		i = 0;
		while (i < PROG_LEN) begin
			inst_valid = 1'b1;
			inst = prog[i];
			@(negedge clk);
			taken = inst_ready;
			if (!taken) begin
				stalled_pushes++;
			end
			@(posedge clk);
			#DRIVE_DLY;
			if (taken) begin
				i++;
			end
		end
		inst_valid = 1'b0;
		inst = '0;
	endtask

	// next tag in program order must show up on this port
	task automatic check_retire(input int port);
		int tag;
		tag = int'(retire_tag[port]);
		assert (next_tag < PROG_LEN) else
			fail_run("a retire appeared after the whole program had retired");
		assert (tag == next_tag) else
			fail_run(mismatch_text($sformatf("retire_tag_o[%0d]", port), 32'(tag),
				32'(next_tag)));
		assert (retire_rd[port] == exp_rd[tag]) else
			fail_run(mismatch_text($sformatf("retire_rd_o[%0d]", port), 32'(retire_rd[port]),
				32'(exp_rd[tag])));
		assert (retire_value[port] == exp_value[tag]) else
			fail_run(mismatch_text($sformatf("retire_value_o[%0d]", port),
				retire_value[port], exp_value[tag]));
		if (prog[tag].op == issue_pkg::OP_MUL) begin
			assert (port == 1) else
				fail_run($sformatf("multiply with tag %0d retired on port 0", tag));
		end
		retire_cycle[tag] = cycle_cnt;
		next_tag++;
	endtask

	// retire outputs are stable at the falling edge
	always @(negedge clk) begin
		int first;
		if (rst_n) begin
			cycle_cnt++;
			if (retire_valid == 2'b11) begin
				// lower tag comes from whichever port took head 0
				first = (int'(retire_tag[1]) == next_tag) ? 1 : 0;
				if (int'(retire_tag[0]) >= C_START && int'(retire_tag[0]) < E_START &&
						int'(retire_tag[1]) >= C_START && int'(retire_tag[1]) < E_START) begin
					dual_in_block++;
				end
				check_retire(first);
				check_retire(1 - first);
			end else if (retire_valid[0]) begin
				check_retire(0);
			end else if (retire_valid[1]) begin
				check_retire(1);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout, retirement stalled before the whole program retired");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		lfsr_state = LFSR_SEED;
		next_tag = 0;
		cycle_cnt = 0;
		dual_in_block = 0;
		stalled_pushes = 0;
		build_program();
		run_reference();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		// idle state right after reset
		@(negedge clk);
		assert (retire_valid == 2'b00) else
			fail_run(mismatch_text("retire_valid_o", 32'(retire_valid), 32'h0));
		assert (inst_ready) else
			fail_run("queue not ready to accept right after reset");
		@(posedge clk);
		#DRIVE_DLY;
		push_program();
		wait (next_tag == PROG_LEN);
		repeat (2) @(posedge clk);
		assert (dual_in_block > 0) else
			fail_run("no cycle retired on both ports in the independent block");
		assert (stalled_pushes > 0) else
			fail_run("queue never pushed back during the multiply chain");
		// mul pairs can never share a retire cycle
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			if (prog[i].op == issue_pkg::OP_MUL && prog[i + 1].op == issue_pkg::OP_MUL) begin
				assert (retire_cycle[i] != retire_cycle[i + 1]) else
					fail_run($sformatf("multiplies %0d and %0d retired in one cycle", i, i + 1));
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* files.f */
+incdir+test
source/issue_pkg.sv
source/inst_queue.sv
source/issue.sv
source/reg_file.sv
source/mul_timer.sv
source/exec_pipe.sv
source/dual_issue_top.sv
test/tb_dual_issue.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_dual_issue \
	-f files.f -o sim_dual_issue
./obj_dir/sim_dual_issue 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
echo "simulation passed"
